// File: dcache.f
design/dcache_pkg.sv
design/dcache_way_store.sv
design/dcache_plru.sv
design/dcache_lookup.sv
design/dcache_ctrl.sv
design/dcache.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
BUILD_DIR ?= obj_dir
FILELIST  ?= dcache.f
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/tb_dcache.sv
`timescale 1ns/1ns

module tb_dcache
    import dcache_pkg::*;
();

    localparam int reset_cycles   = 8;
    localparam int directed_ops   = 21;
    localparam int random_ops     = 500;
    localparam int pool_sets      = 3;
    localparam int pool_tags      = 6;
    localparam int readback_ops   = pool_sets * pool_tags * 8;
    localparam int timeout_cycles =
        (directed_ops + random_ops + readback_ops) * 40 + reset_cycles;

    logic     clk;
    logic     rst;
    cpu_req_t cpu_req;
    word_t    rdata;
    logic     resp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    addr_t    peek_addr;
    line_t    peek_line;

    int mismatches = 0;
    int failures   = 0;
    int cycle_count = 0;

    // Reference model state
    logic [7:0] gold [addr_t];
    logic       m_valid [num_sets][num_ways];
    tag_t       m_tag [num_sets][num_ways];
    logic       m_dirty [num_sets][num_ways];
    plru_t      m_plru [num_sets];
    logic [31:0] lcg_state;

    logic  exp_read;
    word_t exp_rdata;
    int    exp_wb;
    addr_t exp_wb_addr;
    line_t exp_wb_line;
    logic  exp_refill;

    int       wb_count = 0;
    addr_t    wb_addr;
    line_t    wb_line;
    int       rf_count = 0;
    addr_t    rf_addr;
    mem_req_t prev_req;
    logic     prev_pending;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    dcache uut (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .rdata   (rdata),
        .resp    (resp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    tb_mem_model u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .peek_addr (peek_addr),
        .peek_line (peek_line)
    );

    task automatic check(input string name, input logic [319:0] got, input logic [319:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic [7:0] gold_byte(addr_t a);
        word_t w;
        addr_t wa;
        if (gold.exists(a)) begin
            return gold[a];
        end
        wa = {a[31:2], 2'b00};
        w  = (wa * 32'h0100_0193) ^ 32'hc3a5_5a3c;
        return w[8*a[1:0] +: 8];
    endfunction

    function automatic line_t gold_line(addr_t base);
        line_t l;
        for (int b = 0; b < line_bytes; b++) begin
            l[8*b +: 8] = gold_byte(base + addr_t'(b));
        end
        return l;
    endfunction

    // Tree PLRU with bit 0 picking the half and bits 1 and 2 the way in it
    function automatic way_t plru_victim(plru_t p);
        return p[0] ? {1'b1, p[2]} : {1'b0, p[1]};
    endfunction

    function automatic plru_t plru_touch(plru_t p, way_t w);
        p[0] = ~w[1];
        if (w[1]) begin
            p[2] = ~w[0];
        end else begin
            p[1] = ~w[0];
        end
        return p;
    endfunction

    // ==============================
    // Reference model
    // ==============================

    function automatic void predict(addr_t addr, byte_en_t wmask, word_t wdata);
        set_t  s;
        tag_t  t;
        way_t  w;
        logic  found;
        addr_t wa;
        s     = addr[offset_bits +: set_bits];
        t     = addr[offset_bits + set_bits +: tag_bits];
        wa    = {addr[31:2], 2'b00};
        found = 1'b0;
        w     = '0;
        exp_wb = 0;
        for (int i = 0; i < num_ways; i++) begin
            if (m_valid[s][i] && m_tag[s][i] == t) begin
                found = 1'b1;
                w     = way_t'(i);
            end
        end
        exp_refill = !found;
        if (!found) begin
            w = plru_victim(m_plru[s]);
            if (m_valid[s][w] && m_dirty[s][w]) begin
                exp_wb      = 1;
                exp_wb_addr = {m_tag[s][w], s, 5'b0};
                exp_wb_line = gold_line(exp_wb_addr);
            end
            m_valid[s][w] = 1'b1;
            m_tag[s][w]   = t;
            m_dirty[s][w] = 1'b0;
        end
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) begin
                gold[wa + addr_t'(b)] = wdata[8*b +: 8];
            end
        end
        if (wmask != 0) begin
            m_dirty[s][w] = 1'b1;
        end
        exp_rdata = {gold_byte(wa + 3), gold_byte(wa + 2), gold_byte(wa + 1), gold_byte(wa)};
        m_plru[s] = plru_touch(m_plru[s], w);
    endfunction

    function automatic addr_t make_addr(tag_t t, set_t s, logic [2:0] word);
        return {t, s, word, 2'b00};
    endfunction

    // One request, then wait for resp; cycles counts from the capture edge
    task automatic do_op(input addr_t addr, input byte_en_t rmask, input byte_en_t wmask,
                         input word_t wdata, output int cycles);
        int start_wb;
        int start_rf;
        @(posedge clk);
        predict(addr, wmask, wdata);
        exp_read = (rmask != 0);
        start_wb = wb_count;
        start_rf = rf_count;
        cycles   = 0;
        cpu_req <= '{addr: addr, rmask: rmask, wmask: wmask, wdata: wdata};
        @(posedge clk);
        cpu_req <= '0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!resp);
        check("write_back_count", wb_count - start_wb, exp_wb);
        if (exp_wb == 1 && wb_count - start_wb == 1) begin
            check("mem_req.addr", wb_addr, exp_wb_addr);
            check("mem_req.wdata", wb_line, exp_wb_line);
        end
        check("refill_count", rf_count - start_rf, exp_refill);
        if (exp_refill && rf_count - start_rf == 1) begin
            check("mem_req.addr", rf_addr, {addr[31:5], 5'b0});
        end
    endtask

    // Compare process for read data
    always @(negedge clk) begin
        if (!rst && resp && exp_read) begin
            check("rdata", rdata, exp_rdata);
        end
    end

    // Memory port monitor
    always @(negedge clk) begin
        if (rst) begin
            prev_pending = 1'b0;
        end else begin
            if (mem_req.read && mem_req.write) begin
                failures++;
                $display("memory read and write were requested in the same cycle");
            end
            if (prev_pending) begin
                check("mem_req.addr", mem_req.addr, prev_req.addr);
                check("mem_req.read", mem_req.read, prev_req.read);
                check("mem_req.write", mem_req.write, prev_req.write);
                if (mem_req.write) begin
                    check("mem_req.wdata", mem_req.wdata, prev_req.wdata);
                end
                check("resp", resp, 1'b0);
            end
            if (mem_req.write && mem_rsp.ready) begin
                wb_count++;
                wb_addr = mem_req.addr;
                wb_line = mem_req.wdata;
            end
            if (mem_req.read && mem_rsp.rvalid) begin
                rf_count++;
                rf_addr = mem_req.addr;
            end
            prev_pending = (mem_req.read && !mem_rsp.rvalid) ||
                           (mem_req.write && !mem_rsp.ready);
            prev_req = mem_req;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            failures++;
            $display("simulation ran past %0d cycles without finishing", timeout_cycles);
            $display("done: %0d mismatches, %0d other errors", mismatches, failures);
            $display("test failed");
            $finish;
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    initial begin
        int          lat;
        addr_t       a;
        logic [15:0] r;
        set_t        s;
        tag_t        t;
        rst       = 1'b1;
        cpu_req   = '0;
        peek_addr = '0;
        exp_read  = 1'b0;
        lcg_state = 32'd11057;
        for (int i = 0; i < num_sets; i++) begin
            m_plru[i] = '0;
            for (int w = 0; w < num_ways; w++) begin
                m_valid[i][w] = 1'b0;
                m_dirty[i][w] = 1'b0;
                m_tag[i][w]   = '0;
            end
        end
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // Cold read miss, then a hit in the same line
        a         = 32'h0000_1004;
        peek_addr = {a[31:5], 5'b0};
        do_op(a, 4'hf, 4'h0, '0, lat);
        check("rdata", rdata, peek_line[32*a[4:2] +: 32]);
        do_op(a + 4, 4'hf, 4'h0, '0, lat);
        check("hit_read_latency", lat, 1);

        // Byte-masked writes merged into one word
        do_op(a + 8, 4'h0, 4'b0101, 32'h1122_3344, lat);
        check("hit_write_latency", lat, 2);
        do_op(a + 8, 4'h0, 4'b1010, 32'haabb_ccdd, lat);
        do_op(a + 8, 4'hf, 4'h0, '0, lat);

        // Five dirty lines in set 3 force dirty evictions
        for (int k = 1; k <= 5; k++) begin
            do_op(make_addr(tag_t'(k * 16 + 1), 4'd3, 3'(k)), 4'h0, 4'hf, 32'hd000_0000 + k, lat);
        end
        for (int k = 1; k <= 5; k++) begin
            do_op(make_addr(tag_t'(k * 16 + 1), 4'd3, 3'(k)), 4'hf, 4'h0, '0, lat);
        end

        // Clean evictions in set 6
        for (int k = 1; k <= 5; k++) begin
            do_op(make_addr(tag_t'(k * 5 + 200), 4'd6, 3'(k)), 4'hf, 4'h0, '0, lat);
        end
        do_op(make_addr(tag_t'(205), 4'd6, 3'd1), 4'hf, 4'h0, '0, lat);

        // Random traffic over a small pool
        repeat (random_ops) begin
            r = next_rand();
            s = set_t'(2 + 3 * (r[3:0] % pool_sets));
            t = tag_t'(100 + 37 * (r[7:4] % pool_tags));
            a = make_addr(t, s, r[10:8]);
            if (r[11]) begin
                do_op(a, 4'hf, 4'h0, '0, lat);
            end else begin
                do_op(a, 4'h0, byte_en_t'(1 + r[15:12] % 15), {next_rand(), next_rand()}, lat);
            end
        end

        for (int i = 0; i < pool_sets; i++) begin
            for (int j = 0; j < pool_tags; j++) begin
                for (int w = 0; w < 8; w++) begin
                    a = make_addr(tag_t'(100 + 37 * j), set_t'(2 + 3 * i), 3'(w));
                    do_op(a, 4'hf, 4'h0, '0, lat);
                end
            end
        end

        @(posedge clk);
        $display("done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: testbench/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp,
    input  addr_t    peek_addr,
    output line_t    peek_line
);

    line_t       mem [addr_t];
    logic        busy;
    int unsigned wait_left;
    logic [31:0] lcg_state = 32'd11057;

    // Untouched memory holds a pattern built from each word's own address
    function automatic line_t read_line(addr_t base);
        line_t l;
        addr_t a;
        if (mem.exists(base)) begin
            return mem[base];
        end
        for (int i = 0; i < line_bytes / 4; i++) begin
            a = base + addr_t'(4 * i);
            l[32*i +: 32] = (a * 32'h0100_0193) ^ 32'hc3a5_5a3c;
        end
        return l;
    endfunction

    function automatic int unsigned next_latency();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[18:16]);
    endfunction

    assign peek_line = read_line(peek_addr);

    always @(posedge clk) begin
        if (rst) begin
            mem_rsp <= '0;
            busy    <= 1'b0;
        end else begin
            mem_rsp.ready  <= 1'b0;
            mem_rsp.rvalid <= 1'b0;
            if (mem_rsp.ready || mem_rsp.rvalid) begin
                // Handshake just completed, the request is still the old one
                busy <= 1'b0;
            end else if (busy) begin
                if (wait_left == 0) begin
                    if (mem_req.write) begin
                        mem[mem_req.addr] = mem_req.wdata;
                        mem_rsp.ready <= 1'b1;
                    end else begin
                        mem_rsp.rdata  <= read_line(mem_req.addr);
                        mem_rsp.rvalid <= 1'b1;
                    end
                end else begin
                    wait_left <= wait_left - 1;
                end
            end else if (mem_req.read || mem_req.write) begin
                busy      <= 1'b1;
                wait_left <= next_latency();
            end
        end
    end

endmodule

// File: design/dcache.sv
`timescale 1ns/1ns

module dcache
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req,
    output word_t    rdata,
    output logic     resp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    stage_reg_t          stage;
    tag_t                in_tag;
    set_t                in_set;
    offset_t             in_offset;
    set_t                array_set;
    offset_t             word_base;
    logic                live;
    logic                is_write;

    logic [num_ways-1:0] way_en;
    logic [num_ways-1:0] way_we;
    line_mask_t          line_mask;
    line_t               line_in;
    logic                tag_we;
    line_t               line_out [num_ways];
    tag_t                tag_out [num_ways];
    logic [num_ways-1:0] dirty_out;
    logic [num_ways-1:0] valid_out;

    logic                hit;
    way_t                hit_way;
    logic                hit_dirty;
    logic                victim_dirty;
    way_t                victim;
    logic                stall;
    logic                allocate;
    logic                write_hit;
    logic                mem_read;
    logic                mem_write;

    assign in_offset = cpu_req.addr[offset_bits-1:0];
    assign in_set    = cpu_req.addr[offset_bits +: set_bits];
    assign in_tag    = cpu_req.addr[offset_bits + set_bits +: tag_bits];

    // ==============================
    // Stage register
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            stage.rmask <= '0;
            stage.wmask <= '0;
        end else if (!stall) begin
            stage <= '{tag: in_tag, set: in_set, offset: in_offset,
                       rmask: cpu_req.rmask, wmask: cpu_req.wmask, wdata: cpu_req.wdata};
        end else if (write_hit) begin
            // Merge done, the slot is free for the next request
            stage.rmask <= '0;
            stage.wmask <= '0;
        end
    end

    assign live      = |stage.rmask || |stage.wmask;
    assign is_write  = |stage.wmask;
    assign word_base = {stage.offset[offset_bits-1:2], 2'b00};
    assign array_set = stall ? stage.set : in_set;

    // ==============================
    // Arrays and write path
    // ==============================

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_we[w] = (allocate && victim == way_t'(w)) || (write_hit && hit_way == way_t'(w));
            way_en[w] = !stall || way_we[w];
        end
    end

    assign line_mask = allocate ? '1 : line_mask_t'(stage.wmask) << word_base;
    assign line_in   = allocate ? mem_rsp.rdata : {(line_bytes / 4){stage.wdata}};
    assign tag_we    = allocate || !hit_dirty;

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        dcache_way_store u_way (
            .clk       (clk),
            .rst       (rst),
            .en        (way_en[w]),
            .we        (way_we[w]),
            .set       (array_set),
            .line_mask (line_mask),
            .line_in   (line_in),
            .tag_in    (stage.tag),
            .dirty_in  (write_hit),
            .tag_we    (tag_we),
            .line_out  (line_out[w]),
            .tag_out   (tag_out[w]),
            .dirty_out (dirty_out[w]),
            .valid_out (valid_out[w])
        );
    end

    dcache_plru u_plru (
        .clk     (clk),
        .rst     (rst),
        .rd_en   (!stall),
        .rd_set  (in_set),
        .upd_en  (resp),
        .upd_set (stage.set),
        .upd_way (hit_way),
        .victim  (victim)
    );

    dcache_lookup u_lookup (
        .stage        (stage),
        .tags         (tag_out),
        .dirty        (dirty_out),
        .valid        (valid_out),
        .victim       (victim),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_dirty    (hit_dirty),
        .victim_dirty (victim_dirty)
    );

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .live         (live),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .is_write     (is_write),
        .mem_rsp      (mem_rsp),
        .stall        (stall),
        .allocate     (allocate),
        .write_hit    (write_hit),
        .mem_read     (mem_read),
        .mem_write    (mem_write)
    );

    // ==============================
    // Memory port and response
    // ==============================

    always_comb begin
        mem_req.read  = mem_read;
        mem_req.write = mem_write;
        mem_req.wdata = line_out[victim];
        if (mem_write) begin
            mem_req.addr = {tag_out[victim], stage.set, offset_t'(0)};
        end else begin
            mem_req.addr = {stage.tag, stage.set, offset_t'(0)};
        end
    end

    assign resp  = (live && !stall) || write_hit;
    assign rdata = line_out[hit_way][8*word_base +: 32];

endmodule

// File: design/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     live,
    input  logic     hit,
    input  logic     victim_dirty,
    input  logic     is_write,
    input  mem_rsp_t mem_rsp,
    output logic     stall,
    output logic     allocate,
    output logic     write_hit,
    output logic     mem_read,
    output logic     mem_write
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        miss;
    logic        store_hit;

    assign miss      = live && !hit;
    assign store_hit = live && hit && is_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    // ==============================
    // Next state
    // ==============================

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (miss) begin
                    state_next = victim_dirty ? s_writeback : s_refill;
                end else if (store_hit) begin
                    state_next = s_write_hit;
                end
            end
            s_writeback: begin
                if (mem_rsp.ready) begin
                    state_next = s_refill;
                end
            end
            s_refill: begin
                if (mem_rsp.rvalid) begin
                    state_next = s_allocate;
                end
            end
            // Back to idle so the stage request looks up the new line
            s_allocate: begin
                state_next = s_idle;
            end
            s_write_hit: begin
                state_next = s_idle;
            end
            default: begin
                state_next = s_idle;
            end
        endcase
    end

    // ==============================
    // Outputs
    // ==============================

    // A store hit also holds the stage for its merge cycle
    assign stall = (state != s_idle) || miss || store_hit;

    // Refill line is written in the cycle it arrives
    assign allocate  = (state == s_refill) && mem_rsp.rvalid;
    assign write_hit = (state == s_write_hit);

    assign mem_read  = (state == s_refill);
    assign mem_write = (state == s_writeback);

endmodule

// File: design/dcache_lookup.sv
`timescale 1ns/1ns

module dcache_lookup
    import dcache_pkg::*;
(
    input  stage_reg_t          stage,
    input  tag_t                tags [num_ways],
    input  logic [num_ways-1:0] dirty,
    input  logic [num_ways-1:0] valid,
    input  way_t                victim,
    output logic                hit,
    output way_t                hit_way,
    output logic                hit_dirty,
    output logic                victim_dirty
);

    logic [num_ways-1:0] match;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            match[w] = valid[w] && (tags[w] == stage.tag);
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |match;

    // Dirty only counts for a valid line
    assign hit_dirty    = hit && dirty[hit_way];
    assign victim_dirty = valid[victim] && dirty[victim];

endmodule

// File: design/dcache_plru.sv
`timescale 1ns/1ns

module dcache_plru
    import dcache_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rd_en,
    input  set_t rd_set,
    input  logic upd_en,
    input  set_t upd_set,
    input  way_t upd_way,
    output way_t victim
);

    plru_t tree [num_sets];
    plru_t rd_bits;
    plru_t upd_bits;

    // Bit 0 picks the half, bits 1 and 2 pick the way inside it
    // Each bit points toward the next victim
    always_comb begin
        upd_bits    = tree[upd_set];
        upd_bits[0] = ~upd_way[1];
        if (upd_way[1]) begin
            upd_bits[2] = ~upd_way[0];
        end else begin
            upd_bits[1] = ~upd_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                tree[s] <= '0;
            end
            rd_bits <= '0;
        end else begin
            if (upd_en) begin
                tree[upd_set] <= upd_bits;
            end
            // Same-set read at the update edge sees the new bits
            if (rd_en) begin
                rd_bits <= (upd_en && upd_set == rd_set) ? upd_bits : tree[rd_set];
            end
        end
    end

    assign victim = rd_bits[0] ? {1'b1, rd_bits[2]} : {1'b0, rd_bits[1]};

endmodule

// File: design/dcache_way_store.sv
`timescale 1ns/1ns

module dcache_way_store
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       en,
    input  logic       we,
    input  set_t       set,
    input  line_mask_t line_mask,
    input  line_t      line_in,
    input  tag_t       tag_in,
    input  logic       dirty_in,
    input  logic       tag_we,
    output line_t      line_out,
    output tag_t       tag_out,
    output logic       dirty_out,
    output logic       valid_out
);

    line_t               lines [num_sets];
    tag_t                tags [num_sets];
    logic [num_sets-1:0] dirty_bits;
    logic [num_sets-1:0] valid_bits;

    line_t merged;
    tag_t  tag_next;
    logic  dirty_next;

    // Byte-masked merge of the incoming line into the stored one
    always_comb begin
        merged = lines[set];
        for (int b = 0; b < line_bytes; b++) begin
            if (we && line_mask[b]) begin
                merged[8*b +: 8] = line_in[8*b +: 8];
            end
        end
    end

    assign tag_next   = (we && tag_we) ? tag_in : tags[set];
    assign dirty_next = (we && tag_we) ? dirty_in : dirty_bits[set];

    // Read register follows the written line in a write cycle
    always_ff @(posedge clk) begin
        if (en) begin
            line_out  <= merged;
            tag_out   <= tag_next;
            dirty_out <= dirty_next;
            if (we) begin
                lines[set]      <= merged;
                tags[set]       <= tag_next;
                dirty_bits[set] <= dirty_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            valid_out  <= 1'b0;
        end else if (en) begin
            valid_out <= we || valid_bits[set];
            if (we) begin
                valid_bits[set] <= 1'b1;
            end
        end
    end

endmodule

// File: design/dcache_pkg.sv
package dcache_pkg;

    // Address split and geometry
    localparam int offset_bits = 5;
    localparam int set_bits    = 4;
    localparam int tag_bits    = 23;
    localparam int num_ways    = 4;
    localparam int way_bits    = 2;
    localparam int plru_bits   = 3;
    localparam int num_sets    = 16;
    localparam int line_bytes  = 32;

    typedef logic [31:0]               addr_t;
    typedef logic [31:0]               word_t;
    typedef logic [3:0]                byte_en_t;
    typedef logic [offset_bits-1:0]    offset_t;
    typedef logic [set_bits-1:0]       set_t;
    typedef logic [tag_bits-1:0]       tag_t;
    typedef logic [8*line_bytes-1:0]   line_t;
    typedef logic [line_bytes-1:0]     line_mask_t;
    typedef logic [way_bits-1:0]       way_t;
    typedef logic [plru_bits-1:0]      plru_t;

    typedef struct packed {
        addr_t    addr;
        byte_en_t rmask;
        byte_en_t wmask;
        word_t    wdata;
    } cpu_req_t;

    typedef struct packed {
        tag_t     tag;
        set_t     set;
        offset_t  offset;
        byte_en_t rmask;
        byte_en_t wmask;
        word_t    wdata;
    } stage_reg_t;

    // Memory side moves whole lines
    typedef struct packed {
        addr_t addr;
        logic  read;
        logic  write;
        line_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        logic  rvalid;
        line_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        s_idle,
        s_writeback,
        s_refill,
        s_allocate,
        s_write_hit
    } ctrl_state_t;

endpackage
